//--- files.f
source/blackjack_pkg.sv
source/card_dealer.sv
source/hand_scorer.sv
source/game_control.sv
source/coin_bank.sv
source/blackjack_top.sv
testbench/blackjack_tb.sv

//--- Bender.yml
package:
  name: blackjack_table

sources:
  - files:
      - source/blackjack_pkg.sv
      - source/card_dealer.sv
      - source/hand_scorer.sv
      - source/game_control.sv
      - source/coin_bank.sv
      - source/blackjack_top.sv
  - target: test
    files:
      - testbench/blackjack_tb.sv

//--- testbench/blackjack_tb.sv
`default_nettype none

module blackjack_tb;

    typedef enum {PRESS_NEXT, PRESS_HIT, PRESS_STAND, PRESS_DOUBLE} button_t;

    localparam int MAX_WAIT = 200;  // cycles per wait loop

    logic clk;
    logic reset;
    logic next;
    logic hit;
    logic stand;
    logic double_down;
    blackjack_pkg::bet_t   bet;
    blackjack_pkg::score_t player_score;
    blackjack_pkg::score_t dealer_score;
    blackjack_pkg::card_t  player_card;
    blackjack_pkg::card_t  dealer_card;
    logic                  player_card_valid;
    logic                  dealer_card_valid;
    blackjack_pkg::coin_t  coins;
    logic win;
    logic lose;
    logic draw;

    blackjack_pkg::card_t player_cards[$];  // cards of the current round
    blackjack_pkg::card_t dealer_cards[$];
    bit          player_pending;            // score due one cycle after a card
    bit          dealer_pending;
    logic [31:0] rng;
    int          model_bal;
    int          error_count;
    int          check_count;
    bit          timed_out;

    blackjack_top UUT (
        .clk               (clk),
        .reset             (reset),
        .next              (next),
        .hit               (hit),
        .stand             (stand),
        .double_down       (double_down),
        .bet               (bet),
        .player_score      (player_score),
        .dealer_score      (dealer_score),
        .player_card       (player_card),
        .player_card_valid (player_card_valid),
        .dealer_card       (dealer_card),
        .dealer_card_valid (dealer_card_valid),
        .coins             (coins),
        .win               (win),
        .lose              (lose),
        .draw              (draw)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            r = (r << 1) | int'(rng[0]);
        end
        return r;
    endfunction

    // soft-ace score of the first n cards of one hand
    function automatic int soft_score(input bit dealer_side, input int n);
        int raw;
        int c;
        bit ace;
        raw = 0;
        ace = 1'b0;
        for (int i = 0; i < n; i++) begin
            c = dealer_side ? int'(dealer_cards[i]) : int'(player_cards[i]);
            raw += c;
            if (c == 1) ace = 1'b1;
        end
        if (ace && raw + 10 <= 21) return raw + 10;
        return raw;
    endfunction

    function automatic blackjack_pkg::outcome_t outcome_ref(input int ps, input int ds);
        if (ps > 21 || (ds <= 21 && ds > ps)) return blackjack_pkg::OUT_LOSE;
        if (ds > 21 || ds < ps) begin
            return (ps == 21) ? blackjack_pkg::OUT_WIN_21 : blackjack_pkg::OUT_WIN;
        end
        return blackjack_pkg::OUT_DRAW;
    endfunction

    // balance after payout, bal already has the stake taken out
    function automatic int settle_ref(input int bal, input int stake,
                                      input blackjack_pkg::outcome_t o);
        int pay;
        case (o)
            blackjack_pkg::OUT_LOSE: pay = 0;
            blackjack_pkg::OUT_DRAW: pay = stake;
            blackjack_pkg::OUT_WIN:  pay = 2 * stake;
            default:                 pay = 4 * stake;
        endcase
        if (bal + pay > 255) return 255;
        return bal + pay;
    endfunction

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic report_error(input string msg);
        error_count++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("Timeout at time %0t: gave up waiting for %s", $time, what);
    endtask

    task automatic press_button(input button_t b);
        case (b)
            PRESS_NEXT:   next = 1'b1;
            PRESS_HIT:    hit = 1'b1;
            PRESS_STAND:  stand = 1'b1;
            PRESS_DOUBLE: double_down = 1'b1;
        endcase
        @(negedge clk);
        next = 1'b0;
        hit = 1'b0;
        stand = 1'b0;
        double_down = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_player_cards(input int count, input string what);
        int t;
        t = 0;
        while (player_cards.size() < count && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
        end
        if (player_cards.size() < count) note_timeout(what);
    endtask

    // ------------------------------------------------------------------
    // card monitor, also compares scores one cycle after each card
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            if (player_pending) begin
                check_count++;
                if (player_score != soft_score(1'b0, player_cards.size())) begin
                    report_error($sformatf("player score %0d, expected %0d", player_score,
                                           soft_score(1'b0, player_cards.size())));
                end
            end
            if (dealer_pending) begin
                check_count++;
                if (dealer_score != soft_score(1'b1, dealer_cards.size())) begin
                    report_error($sformatf("dealer score %0d, expected %0d", dealer_score,
                                           soft_score(1'b1, dealer_cards.size())));
                end
            end
            player_pending = player_card_valid;
            dealer_pending = dealer_card_valid;
            if (player_card_valid) begin
                check_count++;
                if (player_card < 1 || player_card > 10) begin
                    report_error($sformatf("player card %0d out of range", player_card));
                end
                player_cards.push_back(player_card);
            end
            if (dealer_card_valid) begin
                check_count++;
                if (dealer_card < 1 || dealer_card > 10) begin
                    report_error($sformatf("dealer card %0d out of range", dealer_card));
                end
                dealer_cards.push_back(dealer_card);
            end
        end
    end

    // ------------------------------------------------------------------
    // rounds
    // ------------------------------------------------------------------
    task automatic try_bad_bet(input int b);
        int n;
        n = player_cards.size() + dealer_cards.size();
        bet = blackjack_pkg::bet_t'(b);
        press_button(PRESS_NEXT);
        bet = '0;
        idle_cycles(6);  // a refused bet deals nothing
        check_count++;
        if (player_cards.size() + dealer_cards.size() != n) begin
            report_error($sformatf("bet of %0d with balance %0d dealt cards", b, model_bal));
        end
        check_count++;
        if (coins != model_bal) begin
            report_error($sformatf("coins %0d after refused bet, expected %0d", coins, model_bal));
        end
    endtask

    task automatic play_round();
        int b;
        int stake;
        int n;
        int t;
        int ps;
        int ds;
        int decisions;
        int exp_pcount;
        int exp_coins;
        bit hit_taken;
        bit done;
        blackjack_pkg::outcome_t exp_out;

        b = rand_bits(4);
        if (b == 0 || b > model_bal) begin
            try_bad_bet(b);
            return;
        end
        player_cards.delete();
        dealer_cards.delete();
        bet = blackjack_pkg::bet_t'(b);
        press_button(PRESS_NEXT);
        bet = '0;
        model_bal -= b;
        stake = b;
        check_count++;
        if (coins != model_bal) begin
            report_error($sformatf("coins %0d after bet of %0d, expected %0d", coins, b, model_bal));
        end

        // initial deal: player, player, dealer, dealer
        t = 0;
        while (player_cards.size() + dealer_cards.size() < 4 && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
            if (dealer_cards.size() > 0 && player_cards.size() < 2) begin
                report_error("dealer card dealt before both player cards");
            end
        end
        if (player_cards.size() + dealer_cards.size() < 4) begin
            note_timeout("the initial deal");
            return;
        end
        check_count++;
        if (player_cards.size() != 2 || dealer_cards.size() != 2) begin
            report_error($sformatf("deal gave %0d player and %0d dealer cards",
                                   player_cards.size(), dealer_cards.size()));
        end

        exp_pcount = 2;
        hit_taken = 1'b0;
        done = 1'b0;
        decisions = 0;
        while (!done) begin
            ps = soft_score(1'b0, player_cards.size());
            n = player_cards.size();
            if (ps > 21) begin
                done = 1'b1;
            end else if (ps == 21) begin
                press_button(PRESS_HIT);  // must be ignored at 21
                done = 1'b1;
            end else begin
                case ((decisions >= 8) ? 1 : rand_bits(2))
                    1: begin
                        press_button(PRESS_STAND);
                        done = 1'b1;
                    end
                    2: begin
                        press_button(PRESS_DOUBLE);
                        if (!hit_taken && model_bal >= stake) begin
                            model_bal -= stake;
                            stake *= 2;
                            exp_pcount++;
                            check_count++;
                            if (coins != model_bal) begin
                                report_error($sformatf("coins %0d after double, expected %0d",
                                                       coins, model_bal));
                            end
                            wait_player_cards(n + 1, "the double down card");
                            if (timed_out) return;
                            done = 1'b1;
                        end else begin
                            idle_cycles(2);
                            check_count++;
                            if (player_cards.size() != n || coins != model_bal) begin
                                report_error("refused double changed the hand or the coins");
                            end
                        end
                    end
                    default: begin
                        press_button(PRESS_HIT);
                        hit_taken = 1'b1;
                        exp_pcount++;
                        wait_player_cards(n + 1, "a card after hit");
                        if (timed_out) return;
                    end
                endcase
                decisions++;
            end
        end

        // dealer's turn runs until a result flag rises
        t = 0;
        while (!(win || lose || draw) && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
        end
        if (!(win || lose || draw)) begin
            note_timeout("the round result");
            return;
        end

        ps = soft_score(1'b0, player_cards.size());
        ds = soft_score(1'b1, dealer_cards.size());
        exp_out = outcome_ref(ps, ds);
        check_count++;
        if (player_cards.size() != exp_pcount) begin
            report_error($sformatf("player got %0d cards, expected %0d",
                                   player_cards.size(), exp_pcount));
        end
        check_count++;
        if (ps > 21) begin
            if (dealer_cards.size() != 2) begin
                report_error("dealer drew after the player busted");
            end
        end else begin
            for (int k = 2; k < dealer_cards.size(); k++) begin
                if (soft_score(1'b1, k) >= 17) begin
                    report_error($sformatf("dealer drew again at score %0d", soft_score(1'b1, k)));
                end
            end
            if (ds < 17) begin
                report_error($sformatf("dealer stopped at score %0d", ds));
            end
        end
        check_count++;
        if (int'(win) + int'(lose) + int'(draw) != 1 ||
            win != (exp_out == blackjack_pkg::OUT_WIN || exp_out == blackjack_pkg::OUT_WIN_21) ||
            lose != (exp_out == blackjack_pkg::OUT_LOSE) ||
            draw != (exp_out == blackjack_pkg::OUT_DRAW)) begin
            report_error($sformatf("flags win %0b lose %0b draw %0b for player %0d dealer %0d",
                                   win, lose, draw, ps, ds));
        end

        @(negedge clk);  // coins settle one cycle after the flag
        exp_coins = settle_ref(model_bal, stake, exp_out);
        check_count++;
        if (coins != exp_coins) begin
            report_error($sformatf("coins %0d after settlement, expected %0d", coins, exp_coins));
        end
        model_bal = exp_coins;
        check_count++;
        if (!(win || lose || draw)) begin
            report_error("result flag dropped before next");
        end
        press_button(PRESS_NEXT);
        check_count++;
        if (win || lose || draw) begin
            report_error("result flag still set after next");
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        reset = 1'b1;
        next = 1'b0;
        hit = 1'b0;
        stand = 1'b0;
        double_down = 1'b0;
        bet = '0;
        rng = 32'h30f569f9;
        model_bal = 30;
        error_count = 0;
        check_count = 0;
        timed_out = 1'b0;
        player_pending = 1'b0;
        dealer_pending = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_count++;
        if (coins != 30 || player_score != 0 || dealer_score != 0) begin
            report_error($sformatf("after reset coins %0d scores %0d %0d",
                                   coins, player_score, dealer_score));
        end
        check_count++;
        if (player_card_valid || dealer_card_valid || win || lose || draw) begin
            report_error("strobe or result flag high after reset");
        end

        try_bad_bet(0);
        for (int r = 0; r < 40 && !timed_out && model_bal > 0; r++) begin
            play_round();
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/blackjack_top.sv
`default_nettype none

module blackjack_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   next,
    input  wire                   hit,
    input  wire                   stand,
    input  wire                   double_down,
    input  blackjack_pkg::bet_t   bet,
    output blackjack_pkg::score_t player_score,
    output blackjack_pkg::score_t dealer_score,
    output blackjack_pkg::card_t  player_card,
    output logic                  player_card_valid,
    output blackjack_pkg::card_t  dealer_card,
    output logic                  dealer_card_valid,
    output blackjack_pkg::coin_t  coins,
    output logic                  win,
    output logic                  lose,
    output logic                  draw
);

    blackjack_pkg::card_t    card;
    blackjack_pkg::outcome_t outcome;
    logic draw_card;
    logic player_add;
    logic dealer_add;
    logic player_clear;
    logic dealer_clear;
    logic place_bet;
    logic double_stake;
    logic settle;
    logic bet_ok;
    logic double_ok;

    // one shared card source, the add strobes say whose card it is
    assign player_card       = card;
    assign dealer_card       = card;
    assign player_card_valid = player_add;
    assign dealer_card_valid = dealer_add;

    card_dealer u_card_dealer (
        .clk       (clk),
        .reset     (reset),
        .draw_card (draw_card),
        .card      (card)
    );

    hand_scorer u_player_hand (
        .clk   (clk),
        .reset (reset),
        .clear (player_clear),
        .add   (player_add),
        .card  (card),
        .score (player_score)
    );

    hand_scorer u_dealer_hand (
        .clk   (clk),
        .reset (reset),
        .clear (dealer_clear),
        .add   (dealer_add),
        .card  (card),
        .score (dealer_score)
    );

    game_control u_game_control (
        .clk          (clk),
        .reset        (reset),
        .next         (next),
        .hit          (hit),
        .stand        (stand),
        .double_down  (double_down),
        .bet_ok       (bet_ok),
        .double_ok    (double_ok),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .draw_card    (draw_card),
        .player_add   (player_add),
        .dealer_add   (dealer_add),
        .player_clear (player_clear),
        .dealer_clear (dealer_clear),
        .place_bet    (place_bet),
        .double_stake (double_stake),
        .settle       (settle),
        .outcome      (outcome),
        .win          (win),
        .lose         (lose),
        .draw         (draw)
    );

    coin_bank u_coin_bank (
        .clk          (clk),
        .reset        (reset),
        .bet          (bet),
        .place_bet    (place_bet),
        .double_stake (double_stake),
        .settle       (settle),
        .outcome      (outcome),
        .bet_ok       (bet_ok),
        .double_ok    (double_ok),
        .coins        (coins)
    );

endmodule

`default_nettype wire

//--- source/coin_bank.sv
`default_nettype none

module coin_bank (
    input  wire                     clk,
    input  wire                     reset,
    input  blackjack_pkg::bet_t     bet,
    input  wire                     place_bet,
    input  wire                     double_stake,
    input  wire                     settle,
    input  blackjack_pkg::outcome_t outcome,
    output logic                    bet_ok,
    output logic                    double_ok,
    output blackjack_pkg::coin_t    coins
);

    blackjack_pkg::coin_t balance;
    blackjack_pkg::coin_t stake;     // coins at risk this round
    blackjack_pkg::coin_t paid_out;  // balance after settlement
    logic [9:0]           payout;    // up to 4x stake
    logic [10:0]          total;

    assign bet_ok    = (bet != '0) && (blackjack_pkg::coin_t'(bet) <= balance);
    assign double_ok = (stake <= balance);
    assign coins     = balance;

    // ----------------------------------------------------------------------
    // settlement
    // ----------------------------------------------------------------------
    always_comb begin
        case (outcome)
            blackjack_pkg::OUT_LOSE: payout = '0;
            blackjack_pkg::OUT_DRAW: payout = {2'b00, stake};      // stake back
            blackjack_pkg::OUT_WIN:  payout = {1'b0, stake, 1'b0}; // 2x
            default:                 payout = {stake, 2'b00};      // 4x at 21
        endcase
        total    = 11'(payout) + 11'(balance);
        paid_out = (total[10:8] != 3'b000) ? '1 : total[7:0];  // saturate
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            balance <= blackjack_pkg::INITIAL_COINS;
            stake   <= '0;
        end else if (place_bet) begin
            balance <= balance - blackjack_pkg::coin_t'(bet);
            stake   <= blackjack_pkg::coin_t'(bet);
        end else if (double_stake) begin
            balance <= balance - stake;
            stake   <= {stake[6:0], 1'b0};
        end else if (settle) begin
            balance <= paid_out;
        end
    end

endmodule

`default_nettype wire

//--- source/game_control.sv
`default_nettype none

module game_control (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     next,
    input  wire                     hit,
    input  wire                     stand,
    input  wire                     double_down,
    input  wire                     bet_ok,
    input  wire                     double_ok,
    input  blackjack_pkg::score_t   player_score,
    input  blackjack_pkg::score_t   dealer_score,
    output logic                    draw_card,
    output logic                    player_add,
    output logic                    dealer_add,
    output logic                    player_clear,
    output logic                    dealer_clear,
    output logic                    place_bet,
    output logic                    double_stake,
    output logic                    settle,
    output blackjack_pkg::outcome_t outcome,
    output logic                    win,
    output logic                    lose,
    output logic                    draw
);

    blackjack_pkg::game_state_t state;
    blackjack_pkg::game_state_t state_next;

    logic [1:0] deal_cnt;   // p, p, d, d
    logic       hit_seen;   // blocks a late double
    logic       doubled;    // waiting for the doubled card's score
    logic       settled;    // result already paid out

    // ----------------------------------------------------------------------
    // next state and strobes
    // ----------------------------------------------------------------------
    always_comb begin
        state_next   = state;
        draw_card    = 1'b0;
        player_add   = 1'b0;
        dealer_add   = 1'b0;
        player_clear = 1'b0;
        dealer_clear = 1'b0;
        place_bet    = 1'b0;
        double_stake = 1'b0;
        case (state)
            blackjack_pkg::ST_BETTING: begin
                if (next && bet_ok) begin
                    player_clear = 1'b1;
                    dealer_clear = 1'b1;
                    place_bet    = 1'b1;
                    state_next   = blackjack_pkg::ST_DEAL;
                end
            end
            blackjack_pkg::ST_DEAL: begin
                draw_card  = 1'b1;
                player_add = !deal_cnt[1];
                dealer_add = deal_cnt[1];
                if (deal_cnt == 2'd3) begin
                    state_next = blackjack_pkg::ST_PLAYER;
                end
            end
            blackjack_pkg::ST_PLAYER: begin
                // score here already includes the last card drawn
                if (player_score > blackjack_pkg::BLACKJACK) begin
                    state_next = blackjack_pkg::ST_RESULT;  // bust, dealer skips
                end else if (doubled || player_score == blackjack_pkg::BLACKJACK) begin
                    state_next = blackjack_pkg::ST_DEALER_CHECK;
                end else if (hit) begin
                    draw_card  = 1'b1;
                    player_add = 1'b1;
                end else if (stand) begin
                    state_next = blackjack_pkg::ST_DEALER_CHECK;
                end else if (double_down && !hit_seen && double_ok) begin
                    double_stake = 1'b1;
                    draw_card    = 1'b1;
                    player_add   = 1'b1;
                end
            end
            blackjack_pkg::ST_DEALER_DRAW: begin
                draw_card  = 1'b1;
                dealer_add = 1'b1;
                state_next = blackjack_pkg::ST_DEALER_CHECK;
            end
            blackjack_pkg::ST_DEALER_CHECK: begin
                if (dealer_score >= blackjack_pkg::DEALER_STAND) begin
                    state_next = blackjack_pkg::ST_RESULT;
                end else begin
                    state_next = blackjack_pkg::ST_DEALER_DRAW;
                end
            end
            blackjack_pkg::ST_RESULT: begin
                if (next) begin
                    state_next = blackjack_pkg::ST_BETTING;
                end
            end
            default: state_next = blackjack_pkg::ST_BETTING;
        endcase
    end

    // ----------------------------------------------------------------------
    // state registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= blackjack_pkg::ST_BETTING;
            deal_cnt <= 2'd0;
            hit_seen <= 1'b0;
            doubled  <= 1'b0;
            settled  <= 1'b0;
        end else begin
            state   <= state_next;
            settled <= (state == blackjack_pkg::ST_RESULT);
            if (state == blackjack_pkg::ST_DEAL) begin
                deal_cnt <= deal_cnt + 2'd1;  // wraps back to 0 after four
            end
            if (place_bet) begin
                hit_seen <= 1'b0;
                doubled  <= 1'b0;
            end else begin
                if (state == blackjack_pkg::ST_PLAYER && player_add && !double_stake) begin
                    hit_seen <= 1'b1;
                end
                if (double_stake) begin
                    doubled <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // outcome
    // ----------------------------------------------------------------------
    always_comb begin
        if (player_score > blackjack_pkg::BLACKJACK ||
            (dealer_score <= blackjack_pkg::BLACKJACK && dealer_score > player_score)) begin
            outcome = blackjack_pkg::OUT_LOSE;
        end else if (dealer_score > blackjack_pkg::BLACKJACK || dealer_score < player_score) begin
            if (player_score == blackjack_pkg::BLACKJACK) begin
                outcome = blackjack_pkg::OUT_WIN_21;
            end else begin
                outcome = blackjack_pkg::OUT_WIN;
            end
        end else begin
            outcome = blackjack_pkg::OUT_DRAW;
        end
    end

    assign settle = (state == blackjack_pkg::ST_RESULT) && !settled;  // first result cycle
    assign lose = (state == blackjack_pkg::ST_RESULT) && (outcome == blackjack_pkg::OUT_LOSE);
    assign draw = (state == blackjack_pkg::ST_RESULT) && (outcome == blackjack_pkg::OUT_DRAW);
    assign win  = (state == blackjack_pkg::ST_RESULT) &&
                  (outcome == blackjack_pkg::OUT_WIN || outcome == blackjack_pkg::OUT_WIN_21);

endmodule

`default_nettype wire

//--- source/hand_scorer.sv
`default_nettype none

module hand_scorer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   clear,
    input  wire                   add,
    input  blackjack_pkg::card_t  card,
    output blackjack_pkg::score_t score
);

    blackjack_pkg::score_t raw_sum;  // every ace counted as 1
    logic                  has_ace;
    logic                  promote;

    // ----------------------------------------------------------------------
    // hand accumulation
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raw_sum <= '0;
            has_ace <= 1'b0;
        end else if (clear) begin
            raw_sum <= '0;
            has_ace <= 1'b0;
        end else if (add) begin
            raw_sum <= raw_sum + blackjack_pkg::score_t'(card);
            if (card == 4'd1) begin
                has_ace <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // soft-ace score
    // ----------------------------------------------------------------------

    // one ace can count as 11 while the hand stays at 21 or below
    assign promote = has_ace &&
                     (raw_sum <= (blackjack_pkg::BLACKJACK - blackjack_pkg::ACE_BONUS));

    always_comb begin
        if (promote) begin
            score = raw_sum + blackjack_pkg::ACE_BONUS;
        end else begin
            score = raw_sum;
        end
    end

endmodule

`default_nettype wire

//--- source/card_dealer.sv
`default_nettype none

module card_dealer (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  draw_card,
    output blackjack_pkg::card_t card
);

    logic [15:0] lfsr;
    logic        feedback;
    logic [3:0]  rank;     // 0..12 before capping

    // ----------------------------------------------------------------------
    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    // ----------------------------------------------------------------------
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= blackjack_pkg::LFSR_SEED;
        end else if (draw_card) begin
            lfsr <= {lfsr[14:0], feedback};  // one step per dealt card
        end
    end

    // ----------------------------------------------------------------------
    // card mapping
    // ----------------------------------------------------------------------

    // thirteen ranks, ace first
    assign rank = 4'(lfsr % 16'd13);

    always_comb begin
        if (rank >= 4'd9) begin
            card = 4'd10;              // ten, jack, queen, king
        end else begin
            card = rank + 4'd1;        // ace through nine
        end
    end

endmodule

`default_nettype wire

//--- source/blackjack_pkg.sv
`default_nettype none

package blackjack_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    typedef logic [3:0] card_t;   // 1 = ace, faces count 10
    typedef logic [4:0] score_t;  // raw sum or soft-ace score
    typedef logic [3:0] bet_t;    // switch value 0..15
    typedef logic [7:0] coin_t;   // saturates at 255

    // ----------------------------------------------------------------------
    // table FSM and round result
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_BETTING,
        ST_DEAL,
        ST_PLAYER,
        ST_DEALER_DRAW,
        ST_DEALER_CHECK,
        ST_RESULT
    } game_state_t;

    typedef enum logic [1:0] {
        OUT_LOSE,
        OUT_DRAW,
        OUT_WIN,
        OUT_WIN_21   // win with exactly 21, pays four times
    } outcome_t;

    // ----------------------------------------------------------------------
    // constants
    // ----------------------------------------------------------------------
    localparam coin_t  INITIAL_COINS = 8'd30;
    localparam score_t DEALER_STAND  = 5'd17;
    localparam score_t BLACKJACK     = 5'd21;
    localparam score_t ACE_BONUS     = 5'd10;  // ace as 11 instead of 1

    // card LFSR start, any nonzero value
    localparam logic [15:0] LFSR_SEED = 16'hace1;

endpackage

`default_nettype wire
